//--- verilog.f
lane_cfg_pkg.sv
lane_insn_pkg.sv
lane_sequencer.sv
operand_requester.sv
vector_regfile.sv
lane_alu.sv
lane.sv
lane_checker.sv
tb_lane.sv

//--- run.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it, then decide from the log
verilator --binary --timing --assert -f verilog.f --top-module tb_lane -o Vtb_lane \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_lane > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

//--- tb_lane.sv
// Testbench for the vector lane. Loads the registers, runs ALU and store
// instructions with random data and checks the store stream against a model.

`timescale 1ns/10ps

module tb_lane;

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  // Longest wait for any DUT event, in cycles
  localparam int MaxWait = 100;

  logic      clk_i;
  logic      rst_ni;
  lane_req_t req_i;
  logic      req_valid_i;
  vrf_wr_t   ldu_wr_i;
  logic      ldu_wr_valid_i;
  logic      busy_o;
  logic      done_o;
  elem_t     stu_data_o;
  eidx_t     stu_eidx_o;
  logic      stu_valid_o;

  // Reference copy of all registers
  elem_t       model [NrVRegs][NrElems];
  logic [31:0] rng_state;

  lane dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .ldu_wr_i      (ldu_wr_i),
    .ldu_wr_valid_i(ldu_wr_valid_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .stu_data_o    (stu_data_o),
    .stu_eidx_o    (stu_eidx_o),
    .stu_valid_o   (stu_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic elem_t next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic elem_t expected_result(input lane_op_e op, input elem_t a, input elem_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Drives one load strobe for the coming edge, caller moves on
  task automatic load_elem(input vreg_t vreg, input eidx_t eidx, input elem_t data);
    ldu_wr_i       = '{vreg: vreg, eidx: eidx, data: data};
    ldu_wr_valid_i = 1'b1;
    model[vreg][eidx] = data;
  endtask

  task automatic check_quiet(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      assert (!busy_o) else fail_run($sformatf("error: busy_o = 0x%0h, expected 0x0", busy_o));
      assert (!done_o) else fail_run($sformatf("error: done_o = 0x%0h, expected 0x0", done_o));
      assert (!stu_valid_o)
        else fail_run($sformatf("error: stu_valid_o = 0x%0h, expected 0x0", stu_valid_o));
      @(negedge clk_i);
    end
  endtask

  task automatic wait_idle();
    int cyc;
    cyc = 0;
    while (busy_o && cyc < MaxWait) begin
      @(negedge clk_i);
      cyc++;
    end
    assert (!busy_o) else fail_run("timeout waiting for busy_o to drop");
  endtask

  ////////////////////
  // Instruction runs
  ////////////////////

  // Optional load traffic into bg_vreg while the instruction runs
  task automatic run_insn(input lane_op_e insn_op, input vreg_t vd, input vreg_t vs1,
                          input vreg_t vs2, input vlen_t vl, input logic bg_en,
                          input vreg_t bg_vreg);
    int   n_st;
    int   n_ld;
    int   cyc;
    logic finished;
    n_st     = 0;
    n_ld     = 0;
    cyc      = 0;
    finished = 1'b0;
    wait_idle();
    req_i       = '{op: insn_op, vd: vd, vs1: vs1, vs2: vs2, vl: vl};
    req_valid_i = 1'b1;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (!finished && cyc < MaxWait) begin
      ldu_wr_valid_i = 1'b0;
      // Busy from the cycle after acceptance up to and including done
      assert (busy_o) else fail_run($sformatf("error: busy_o = 0x%0h, expected 0x1", busy_o));
      if (stu_valid_o) begin
        assert (insn_op == OP_STORE) else fail_run("stu_valid_o pulsed during an ALU instruction");
        assert (n_st < int'(vl)) else fail_run("more store strobes than the vector length");
        assert (stu_eidx_o == eidx_t'(n_st))
          else fail_run($sformatf("error: stu_eidx_o = 0x%0h, expected 0x%0h", stu_eidx_o, n_st));
        assert (stu_data_o == model[vs1][n_st])
          else fail_run($sformatf("error: stu_data_o = 0x%08h, expected 0x%08h",
                                  stu_data_o, model[vs1][n_st]));
        n_st++;
      end
      if (done_o) begin
        finished = 1'b1;
      end else begin
        if (bg_en && n_ld < 2 * NrElems) begin
          load_elem(bg_vreg, eidx_t'(n_ld), next_rand());
          n_ld++;
        end
        @(negedge clk_i);
        cyc++;
      end
    end
    assert (finished) else fail_run("timeout waiting for done_o");
    assert (n_st == ((insn_op == OP_STORE) ? int'(vl) : 0))
      else fail_run($sformatf("error: stu_valid_o strobes = 0x%0h, expected 0x%0h", n_st,
                              (insn_op == OP_STORE) ? int'(vl) : 0));
    // Only the first vl elements of vd change
    if (insn_op != OP_STORE) begin
      for (int i = 0; i < int'(vl); i++) begin
        model[vd][i] = expected_result(insn_op, model[vs1][i], model[vs2][i]);
      end
    end
  endtask

  task automatic store_reg(input vreg_t vreg);
    run_insn(OP_STORE, 3'd0, vreg, 3'd0, 4'd8, 1'b0, 3'd0);
  endtask

  task automatic alu_then_store(input lane_op_e insn_op, input vreg_t vd, input vreg_t vs1,
                                input vreg_t vs2, input vlen_t vl);
    run_insn(insn_op, vd, vs1, vs2, vl, 1'b0, 3'd0);
    store_reg(vd);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    rng_state      = 32'd56;
    rst_ni         = 1'b0;
    req_i          = '0;
    req_valid_i    = 1'b0;
    ldu_wr_i       = '0;
    ldu_wr_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_quiet(6);

    // Fill every register, then stream each one back
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < NrElems; e++) begin
        load_elem(vreg_t'(r), eidx_t'(e), next_rand());
        @(negedge clk_i);
      end
    end
    ldu_wr_valid_i = 1'b0;
    for (int r = 0; r < NrVRegs; r++) begin
      store_reg(vreg_t'(r));
    end

    // Same parity sources share a bank
    alu_then_store(OP_ADD, 3'd4, 3'd0, 3'd2, 4'd8);
    alu_then_store(OP_SUB, 3'd5, 3'd1, 3'd2, 4'd8);
    alu_then_store(OP_AND, 3'd6, 3'd3, 3'd7, 4'd8);
    alu_then_store(OP_OR, 3'd7, 3'd0, 3'd1, 4'd8);
    alu_then_store(OP_XOR, 3'd0, 3'd5, 3'd6, 4'd8);

    // Short vectors, tail of vd untouched
    alu_then_store(OP_SUB, 3'd2, 3'd1, 3'd5, 4'd5);
    alu_then_store(OP_ADD, 3'd3, 3'd4, 3'd7, 4'd3);

    // Load writes next to running instructions
    run_insn(OP_XOR, 3'd1, 3'd2, 3'd6, 4'd8, 1'b1, 3'd5);
    store_reg(3'd1);
    store_reg(3'd5);
    run_insn(OP_STORE, 3'd0, 3'd3, 3'd0, 4'd8, 1'b1, 3'd4);
    store_reg(3'd4);
    run_insn(OP_AND, 3'd6, 3'd7, 3'd1, 4'd6, 1'b1, 3'd0);
    store_reg(3'd6);
    store_reg(3'd0);

    // Empty vectors
    run_insn(OP_STORE, 3'd0, 3'd2, 3'd0, 4'd0, 1'b0, 3'd0);
    alu_then_store(OP_OR, 3'd3, 3'd4, 3'd5, 4'd0);

    wait_idle();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- lane_checker.sv
// Protocol assertions for the lane top level.
// Bound into every lane instance by the bind statement at the end of the file.

`timescale 1ns/10ps

module lane_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic busy_i,
  input logic done_i,
  input logic stu_valid_i
);

  // Done closes an instruction, busy is still high in that cycle
  done_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> busy_i)
    else $error("done_o pulsed while busy_o was low");

  stu_valid_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(stu_valid_i))
    else $error("stu_valid_o is unknown");

  // Store strobes only come from a running store
  stu_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stu_valid_i |-> busy_i)
    else $error("stu_valid_o pulsed while busy_o was low");

  req_only_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> !busy_i)
    else $error("request sent while the lane was busy");

endmodule

bind lane lane_checker i_lane_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_valid_i(req_valid_i),
  .busy_i     (busy_o),
  .done_i     (done_o),
  .stu_valid_i(stu_valid_o)
);

//--- lane.sv
// Top level of one vector lane: sequencer, operand requester, banked VRF and ALU.
// Takes instructions and load writes, emits the store stream.

`timescale 1ns/10ps

module lane (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  lane_insn_pkg::lane_req_t req_i,
  input  logic                     req_valid_i,
  input  lane_insn_pkg::vrf_wr_t   ldu_wr_i,
  input  logic                     ldu_wr_valid_i,
  output logic                     busy_o,
  output logic                     done_o,
  output lane_cfg_pkg::elem_t      stu_data_o,
  output lane_cfg_pkg::eidx_t      stu_eidx_o,
  output logic                     stu_valid_o
);

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  // Sequencer to requester
  elem_op_t elem;
  logic     elem_valid, issue, retire;
  vreg_t    vs1, vs2;
  // Requester to VRF
  logic   [NrBanks-1:0] bank_req, bank_we;
  baddr_t [NrBanks-1:0] bank_addr;
  elem_t  [NrBanks-1:0] bank_wdata, rdata;
  // ALU path
  elem_op_t op;
  logic     op_valid, wb_valid;
  elem_t    opa, opb;
  vrf_wr_t  wb;

  lane_sequencer i_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .issue_i     (issue),
    .retire_i    (retire),
    .elem_o      (elem),
    .elem_valid_o(elem_valid),
    .vs1_o       (vs1),
    .vs2_o       (vs2),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  operand_requester i_requester (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .elem_i        (elem),
    .elem_valid_i  (elem_valid),
    .vs1_i         (vs1),
    .vs2_i         (vs2),
    .ldu_wr_i      (ldu_wr_i),
    .ldu_wr_valid_i(ldu_wr_valid_i),
    .wb_i          (wb),
    .wb_valid_i    (wb_valid),
    .rdata_i       (rdata),
    .bank_req_o    (bank_req),
    .bank_we_o     (bank_we),
    .bank_addr_o   (bank_addr),
    .bank_wdata_o  (bank_wdata),
    .issue_o       (issue),
    .retire_o      (retire),
    .op_o          (op),
    .op_valid_o    (op_valid),
    .opa_o         (opa),
    .opb_o         (opb),
    .stu_data_o    (stu_data_o),
    .stu_eidx_o    (stu_eidx_o),
    .stu_valid_o   (stu_valid_o)
  );

  vector_regfile i_vrf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bank_req_i  (bank_req),
    .bank_we_i   (bank_we),
    .bank_addr_i (bank_addr),
    .bank_wdata_i(bank_wdata),
    .rdata_o     (rdata)
  );

  lane_alu i_alu (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .op_i      (op),
    .op_valid_i(op_valid),
    .opa_i     (opa),
    .opb_i     (opb),
    .wb_o      (wb),
    .wb_valid_o(wb_valid)
  );

endmodule

//--- lane_alu.sv
// Element-wise integer ALU of the lane. One result per cycle, registered,
// handed back to the operand requester as a VRF write.

`timescale 1ns/10ps

module lane_alu (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_insn_pkg::elem_op_t op_i,
  input  logic                    op_valid_i,
  input  lane_cfg_pkg::elem_t     opa_i,
  input  lane_cfg_pkg::elem_t     opb_i,
  output lane_insn_pkg::vrf_wr_t  wb_o,
  output logic                    wb_valid_o
);

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  elem_t   result;
  vrf_wr_t wb_q;
  logic    wb_valid_q;

  ////////////////////
  // Datapath
  ////////////////////

  always_comb begin
    case (op_i.op)
      OP_ADD:  result = opa_i + opb_i;
      OP_SUB:  result = opa_i - opb_i;
      OP_AND:  result = opa_i & opb_i;
      OP_OR:   result = opa_i | opb_i;
      OP_XOR:  result = opa_i ^ opb_i;
      // Stores bypass the ALU
      default: result = '0;
    endcase
  end

  ////////////////////
  // Result register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
      wb_q.vreg <= op_i.vd;
      wb_q.eidx <= op_i.eidx;
      wb_q.data <= result;
    end
  end

  assign wb_o       = wb_q;
  assign wb_valid_o = wb_valid_q;

endmodule

//--- vector_regfile.sv
// Banked vector register file of the lane. One access per bank and cycle,
// read data comes back registered on the following cycle.

`timescale 1ns/10ps

module vector_regfile (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic [lane_cfg_pkg::NrBanks-1:0]                 bank_req_i,
  input  logic [lane_cfg_pkg::NrBanks-1:0]                 bank_we_i,
  input  lane_cfg_pkg::baddr_t [lane_cfg_pkg::NrBanks-1:0] bank_addr_i,
  input  lane_cfg_pkg::elem_t [lane_cfg_pkg::NrBanks-1:0]  bank_wdata_i,
  output lane_cfg_pkg::elem_t [lane_cfg_pkg::NrBanks-1:0]  rdata_o
);

  import lane_cfg_pkg::*;

  elem_t mem_q [NrBanks][BankDepth];
  elem_t [NrBanks-1:0] rdata_q;

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    // Storage
    always_ff @(posedge clk_i) begin
      if (bank_req_i[b] && bank_we_i[b]) begin
        mem_q[b][bank_addr_i[b]] <= bank_wdata_i[b];
      end
    end

    // Read port, holds its value until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_q[b] <= '0;
      end else if (bank_req_i[b] && !bank_we_i[b]) begin
        rdata_q[b] <= mem_q[b][bank_addr_i[b]];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- operand_requester.sv
// Operand requester. Shares the VRF banks between load writes, ALU writeback and
// operand reads, in that priority, and feeds the ALU and the store stream.

`timescale 1ns/10ps

module operand_requester (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  lane_insn_pkg::elem_op_t                       elem_i,
  input  logic                                          elem_valid_i,
  input  lane_cfg_pkg::vreg_t                           vs1_i,
  input  lane_cfg_pkg::vreg_t                           vs2_i,
  input  lane_insn_pkg::vrf_wr_t                        ldu_wr_i,
  input  logic                                          ldu_wr_valid_i,
  input  lane_insn_pkg::vrf_wr_t                        wb_i,
  input  logic                                          wb_valid_i,
  input  lane_cfg_pkg::elem_t [lane_cfg_pkg::NrBanks-1:0]  rdata_i,
  output logic [lane_cfg_pkg::NrBanks-1:0]              bank_req_o,
  output logic [lane_cfg_pkg::NrBanks-1:0]              bank_we_o,
  output lane_cfg_pkg::baddr_t [lane_cfg_pkg::NrBanks-1:0] bank_addr_o,
  output lane_cfg_pkg::elem_t [lane_cfg_pkg::NrBanks-1:0]  bank_wdata_o,
  output logic                                          issue_o,
  output logic                                          retire_o,
  output lane_insn_pkg::elem_op_t                       op_o,
  output logic                                          op_valid_o,
  output lane_cfg_pkg::elem_t                           opa_o,
  output lane_cfg_pkg::elem_t                           opb_o,
  output lane_cfg_pkg::elem_t                           stu_data_o,
  output lane_cfg_pkg::eidx_t                           stu_eidx_o,
  output logic                                          stu_valid_o
);

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  logic [NrBanks-1:0] ld_claim, wb_claim, rd_claim, bank_busy;
  baddr_t [NrBanks-1:0] rd_addr;
  bank_t   ld_bank, wb_in_bank, wbuf_bank, wb_wr_bank, bank_a, bank_b;
  vrf_wr_t wbuf_q, wb_wr;
  logic    wbuf_valid_q, wbuf_valid_d, wbuf_load, wb_wr_valid;
  logic    reads_en, is_store, same_bank, rd_first;
  // Read stage, one cycle behind the bank requests
  elem_op_t rd_op_q;
  logic     rd_valid_q, rd_split_q, a_pend_q, phase_q;
  bank_t    rd_bank_a_q, rd_bank_b_q;
  elem_t    opa_hold_q;

  assign ld_bank    = bank_of(ldu_wr_i.vreg, ldu_wr_i.eidx);
  assign wb_in_bank = bank_of(wb_i.vreg, wb_i.eidx);
  assign wbuf_bank  = bank_of(wbuf_q.vreg, wbuf_q.eidx);
  assign wb_wr_bank = bank_of(wb_wr.vreg, wb_wr.eidx);
  assign bank_a     = bank_of(vs1_i, elem_i.eidx);
  assign bank_b     = bank_of(vs2_i, elem_i.eidx);
  assign is_store   = elem_i.op == OP_STORE;
  assign same_bank  = bank_a == bank_b;

  ////////////////////
  // Writeback buffer
  ////////////////////

  always_comb begin
    wb_wr_valid  = 1'b0;
    wb_wr        = wbuf_q;
    wbuf_valid_d = wbuf_valid_q;
    wbuf_load    = 1'b0;
    if (wbuf_valid_q) begin
      if (!ld_claim[wbuf_bank]) begin
        // Drain oldest first, a new result takes its place
        wb_wr_valid  = 1'b1;
        wbuf_valid_d = wb_valid_i;
        wbuf_load    = wb_valid_i;
      end else if (wb_valid_i) begin
        // Next element of the same vd sits in the other bank, which the load left free
        wb_wr_valid = 1'b1;
        wb_wr       = wb_i;
      end
    end else if (wb_valid_i) begin
      if (!ld_claim[wb_in_bank]) begin
        wb_wr_valid = 1'b1;
        wb_wr       = wb_i;
      end else begin
        wbuf_valid_d = 1'b1;
        wbuf_load    = 1'b1;
      end
    end
  end

  // Reads pause while a result waits, so at most one more can arrive
  assign reads_en = !wbuf_valid_q && !wbuf_valid_d;

  ////////////////////
  // Bank arbitration
  ////////////////////

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      ld_claim[b]  = ldu_wr_valid_i && (ld_bank == bank_t'(b));
      wb_claim[b]  = wb_wr_valid && (wb_wr_bank == bank_t'(b));
      bank_busy[b] = ld_claim[b] | wb_claim[b];
    end
  end

  // Operand reads take whatever the writes leave
  always_comb begin
    rd_claim = '0;
    rd_addr  = '0;
    rd_first = 1'b0;
    issue_o  = 1'b0;
    if (elem_valid_i && reads_en) begin
      if (is_store) begin
        if (!bank_busy[bank_a]) begin
          rd_claim[bank_a] = 1'b1;
          rd_addr[bank_a]  = baddr_of(vs1_i, elem_i.eidx);
          issue_o          = 1'b1;
        end
      end else if (!same_bank) begin
        if (!bank_busy[bank_a] && !bank_busy[bank_b]) begin
          rd_claim[bank_a] = 1'b1;
          rd_claim[bank_b] = 1'b1;
          rd_addr[bank_a]  = baddr_of(vs1_i, elem_i.eidx);
          rd_addr[bank_b]  = baddr_of(vs2_i, elem_i.eidx);
          issue_o          = 1'b1;
        end
      end else if (!bank_busy[bank_a]) begin
        // Same bank, vs1 first and vs2 on a later cycle
        rd_claim[bank_a] = 1'b1;
        if (phase_q) begin
          rd_addr[bank_a] = baddr_of(vs2_i, elem_i.eidx);
          issue_o         = 1'b1;
        end else begin
          rd_addr[bank_a] = baddr_of(vs1_i, elem_i.eidx);
          rd_first        = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      bank_req_o[b]   = ld_claim[b] | wb_claim[b] | rd_claim[b];
      bank_we_o[b]    = ld_claim[b] | wb_claim[b];
      bank_addr_o[b]  = rd_addr[b];
      bank_wdata_o[b] = wb_wr.data;
      if (ld_claim[b]) begin
        bank_addr_o[b]  = baddr_of(ldu_wr_i.vreg, ldu_wr_i.eidx);
        bank_wdata_o[b] = ldu_wr_i.data;
      end else if (wb_claim[b]) begin
        bank_addr_o[b] = baddr_of(wb_wr.vreg, wb_wr.eidx);
      end
    end
  end

  ////////////////////
  // Read stage
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wbuf_valid_q <= 1'b0;
      rd_valid_q   <= 1'b0;
      a_pend_q     <= 1'b0;
      phase_q      <= 1'b0;
    end else begin
      wbuf_valid_q <= wbuf_valid_d;
      rd_valid_q   <= issue_o;
      a_pend_q     <= rd_first;
      if (rd_first) begin
        phase_q <= 1'b1;
      end else if (issue_o) begin
        phase_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wbuf_load) begin
      wbuf_q <= wb_i;
    end
    if (issue_o || rd_first) begin
      rd_bank_a_q <= bank_a;
      rd_bank_b_q <= bank_b;
    end
    if (issue_o) begin
      rd_op_q    <= elem_i;
      rd_split_q <= !is_store && same_bank;
    end
    // First operand of a same-bank pair
    if (a_pend_q) begin
      opa_hold_q <= rdata_i[rd_bank_a_q];
    end
  end

  assign op_o        = rd_op_q;
  assign op_valid_o  = rd_valid_q && (rd_op_q.op != OP_STORE);
  assign opa_o       = rd_split_q ? opa_hold_q : rdata_i[rd_bank_a_q];
  assign opb_o       = rdata_i[rd_bank_b_q];
  assign stu_data_o  = rdata_i[rd_bank_a_q];
  assign stu_eidx_o  = rd_op_q.eidx;
  assign stu_valid_o = rd_valid_q && (rd_op_q.op == OP_STORE);
  // Never both in one cycle, one instruction runs at a time
  assign retire_o    = wb_wr_valid || stu_valid_o;

endmodule

//--- lane_sequencer.sv
// Lane sequencer. Accepts one instruction, hands its elements to the operand
// requester in ascending order and counts retirements until the instruction is done.

`timescale 1ns/10ps

module lane_sequencer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  lane_insn_pkg::lane_req_t     req_i,
  input  logic                         req_valid_i,
  input  logic                         issue_i,
  input  logic                         retire_i,
  output lane_insn_pkg::elem_op_t      elem_o,
  output logic                         elem_valid_o,
  output lane_cfg_pkg::vreg_t          vs1_o,
  output lane_cfg_pkg::vreg_t          vs2_o,
  output logic                         busy_o,
  output logic                         done_o
);

  import lane_cfg_pkg::*;
  import lane_insn_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } seq_state_e;

  seq_state_e state_q, state_d;
  lane_req_t  req_q;
  eidx_t      eidx_q;
  vlen_t      retire_cnt_q;
  logic       last_elem;
  logic       all_retired;

  assign last_elem   = vlen_t'(eidx_q) == req_q.vl - vlen_t'(1);
  assign all_retired = retire_cnt_q == req_q.vl;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          // Nothing to issue for an empty vector
          state_d = (req_i.vl == '0) ? DRAIN : ISSUE;
        end
      end
      ISSUE: begin
        if (issue_i && last_elem) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (all_retired) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      eidx_q       <= '0;
      retire_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && req_valid_i) begin
        eidx_q       <= '0;
        retire_cnt_q <= '0;
      end else begin
        if (issue_i) begin
          eidx_q <= eidx_q + eidx_t'(1);
        end
        if (retire_i) begin
          retire_cnt_q <= retire_cnt_q + vlen_t'(1);
        end
      end
    end
  end

  // Instruction register
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) begin
      req_q <= req_i;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign elem_o       = '{op: req_q.op, vd: req_q.vd, eidx: eidx_q};
  assign elem_valid_o = state_q == ISSUE;
  assign vs1_o        = req_q.vs1;
  assign vs2_o        = req_q.vs2;
  assign busy_o       = state_q != IDLE;
  assign done_o       = (state_q == DRAIN) && all_retired;

endmodule

//--- lane_insn_pkg.sv
// Instruction encodings of the lane and the structs that move between its units.
// Request from the issue side, VRF writes, and per-element operations.

package lane_insn_pkg;

  ////////////////////
  // Opcodes
  ////////////////////

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_XOR   = 3'd4,
    OP_STORE = 3'd5
  } lane_op_e;

  ////////////////////
  // Structs
  ////////////////////

  // One vector instruction; a store streams out vs1
  typedef struct packed {
    lane_op_e            op;
    lane_cfg_pkg::vreg_t vd;
    lane_cfg_pkg::vreg_t vs1;
    lane_cfg_pkg::vreg_t vs2;
    lane_cfg_pkg::vlen_t vl;
  } lane_req_t;

  // Element write into the VRF, from the load unit or the ALU
  typedef struct packed {
    lane_cfg_pkg::vreg_t vreg;
    lane_cfg_pkg::eidx_t eidx;
    lane_cfg_pkg::elem_t data;
  } vrf_wr_t;

  // Work on one element, carried from the sequencer to the ALU
  typedef struct packed {
    lane_op_e            op;
    lane_cfg_pkg::vreg_t vd;
    lane_cfg_pkg::eidx_t eidx;
  } elem_op_t;

endpackage

//--- lane_cfg_pkg.sv
// Fixed shape of one vector lane: element width, register count and VRF banking.
// Also holds the register-to-bank mapping used by the operand requester.

package lane_cfg_pkg;

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;
  // Elements of one register held by this lane
  localparam int unsigned NrElems   = 8;
  localparam int unsigned NrBanks   = 2;
  localparam int unsigned BankDepth = NrVRegs * NrElems / NrBanks;

  typedef logic [ElemWidth-1:0]         elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]   vreg_t;
  typedef logic [$clog2(NrElems)-1:0]   eidx_t;
  // Vector length, 0 up to NrElems inclusive
  typedef logic [$clog2(NrElems+1)-1:0] vlen_t;
  typedef logic [$clog2(NrBanks)-1:0]   bank_t;
  typedef logic [$clog2(BankDepth)-1:0] baddr_t;

  // Low bit of vreg + eidx, so neighbouring elements alternate banks
  function automatic bank_t bank_of(vreg_t vreg, eidx_t eidx);
    return bank_t'(vreg[0] ^ eidx[0]);
  endfunction

  // vreg * 4 + eidx / 2
  function automatic baddr_t baddr_of(vreg_t vreg, eidx_t eidx);
    return {vreg, eidx[2:1]};
  endfunction

endpackage
